// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath widths fixed by RV32I
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_NUM_REGS  32
`define RV_RESET_PC  32'h0000_0000

// Major opcodes
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_OP        7'b0110011
`define RV_OP_MISC_MEM  7'b0001111
`define RV_OP_SYSTEM    7'b1110011

// Branch conditions
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BLT   3'b100
`define RV_F3_BGE   3'b101
`define RV_F3_BLTU  3'b110
`define RV_F3_BGEU  3'b111

// ALU groups shared by OP and OP_IMM
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SRL   3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

`define RV_F3_JALR   3'b000
`define RV_F3_FENCE  3'b000

`define RV_F7_BASE  7'b0000000
`define RV_F7_ALT   7'b0100000  // SUB and SRA/SRAI

`endif

// ==== verilog/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  typedef logic [31:0]           insn_t;   // Always 32 bits with no compressed set
  typedef logic [3:0]            alu_op_t;
  typedef logic [1:0]            pc_sel_t;
  typedef logic [1:0]            wb_sel_t;

  // ALU operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Next PC kinds
  localparam pc_sel_t NPC_SEQ    = 2'd0;
  localparam pc_sel_t NPC_BRANCH = 2'd1;
  localparam pc_sel_t NPC_JAL    = 2'd2;
  localparam pc_sel_t NPC_JALR   = 2'd3;

  // Write-back sources
  localparam wb_sel_t WB_ALU    = 2'd0;
  localparam wb_sel_t WB_IMM    = 2'd1;  // LUI
  localparam wb_sel_t WB_PC4    = 2'd2;  // Link address
  localparam wb_sel_t WB_PC_IMM = 2'd3;  // AUIPC

endpackage

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
  input  wire             clk,
  input  wire             rst,
  input  wire             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t   rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t   rs1_data,
  output rv_pkg::word_t   rs2_data
);

  // No storage behind x0
  rv_pkg::word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;  // Writes to x0 dropped
    end
  end

  // Combinational reads with x0 tied to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             alu_src_imm,
  output logic             rf_we,
  output rv_pkg::wb_sel_t  wb_sel,
  output rv_pkg::pc_sel_t  pc_sel,
  output logic [2:0]       branch_f3,
  output logic             halt,
  output logic             illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;

  assign opcode    = insn[6:0];
  assign rd        = insn[11:7];
  assign funct3    = insn[14:12];
  assign rs1       = insn[19:15];
  assign rs2       = insn[24:20];
  assign funct7    = insn[31:25];
  assign branch_f3 = funct3;

  assign f7_base = (funct7 == `RV_F7_BASE);
  assign f7_alt  = (funct7 == `RV_F7_ALT);

  // Sign-extended immediates; shamt is imm_i[4:0]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    imm         = imm_i;
    alu_op      = rv_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    rf_we       = 1'b0;
    wb_sel      = rv_pkg::WB_ALU;
    pc_sel      = rv_pkg::NPC_SEQ;
    halt        = 1'b0;
    illegal     = 1'b0;

    case (opcode)
      `RV_OP_LUI: begin
        imm    = imm_u;
        rf_we  = 1'b1;
        wb_sel = rv_pkg::WB_IMM;
      end
      `RV_OP_AUIPC: begin
        imm    = imm_u;
        rf_we  = 1'b1;
        wb_sel = rv_pkg::WB_PC_IMM;
      end
      `RV_OP_JAL: begin
        imm    = imm_j;
        rf_we  = 1'b1;
        wb_sel = rv_pkg::WB_PC4;
        pc_sel = rv_pkg::NPC_JAL;
      end
      `RV_OP_JALR: begin
        rf_we   = 1'b1;
        wb_sel  = rv_pkg::WB_PC4;
        pc_sel  = rv_pkg::NPC_JALR;
        illegal = (funct3 != `RV_F3_JALR);
      end
      `RV_OP_BRANCH: begin
        imm     = imm_b;
        pc_sel  = rv_pkg::NPC_BRANCH;
        illegal = (funct3[2:1] == 2'b01);  // funct3 010 and 011 unassigned
      end
      `RV_OP_OP_IMM: begin
        rf_we       = 1'b1;
        alu_src_imm = 1'b1;
        case (funct3)
          `RV_F3_ADD:  alu_op = rv_pkg::ALU_ADD;
          `RV_F3_SLT:  alu_op = rv_pkg::ALU_SLT;
          `RV_F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
          `RV_F3_XOR:  alu_op = rv_pkg::ALU_XOR;
          `RV_F3_OR:   alu_op = rv_pkg::ALU_OR;
          `RV_F3_AND:  alu_op = rv_pkg::ALU_AND;
          `RV_F3_SLL: begin
            alu_op  = rv_pkg::ALU_SLL;
            illegal = !f7_base;
          end
          default: begin  // SRLI or SRAI
            alu_op  = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            illegal = !(f7_base || f7_alt);
          end
        endcase
      end
      `RV_OP_OP: begin
        rf_we = 1'b1;
        // Only ADD/SUB and SRL/SRA accept the alternate funct7
        case (funct3)
          `RV_F3_ADD:  alu_op = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          `RV_F3_SLL:  alu_op = rv_pkg::ALU_SLL;
          `RV_F3_SLT:  alu_op = rv_pkg::ALU_SLT;
          `RV_F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
          `RV_F3_XOR:  alu_op = rv_pkg::ALU_XOR;
          `RV_F3_SRL:  alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          `RV_F3_OR:   alu_op = rv_pkg::ALU_OR;
          default:     alu_op = rv_pkg::ALU_AND;
        endcase
        if (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SRL) begin
          illegal = !(f7_base || f7_alt);
        end else begin
          illegal = !f7_base;
        end
      end
      `RV_OP_MISC_MEM: begin
        illegal = (funct3 != `RV_F3_FENCE);  // FENCE retires as a no-op
      end
      `RV_OP_SYSTEM: begin
        if (insn[31:7] == 25'd0) begin
          halt = 1'b1;  // ECALL
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings fall through to pc+4 with no write
    if (illegal) begin
      rf_we  = 1'b0;
      pc_sel = rv_pkg::NPC_SEQ;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];  // Upper bits of b ignored for shifts
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'd0, lt_signed};
      rv_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      default:          result = '0;  // Unused codes
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_next_pc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_next_pc (
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::pc_sel_t pc_sel,
  input  wire [2:0]       branch_f3,
  input  wire             halt,
  output rv_pkg::word_t   next_pc
);

  logic          taken;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_plus_imm;
  rv_pkg::word_t jalr_sum;

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;
  assign jalr_sum    = rs1_data + imm;

  // Branch condition
  always_comb begin
    case (branch_f3)
      `RV_F3_BEQ:  taken = (rs1_data == rs2_data);
      `RV_F3_BNE:  taken = (rs1_data != rs2_data);
      `RV_F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      `RV_F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      `RV_F3_BLTU: taken = (rs1_data < rs2_data);
      `RV_F3_BGEU: taken = (rs1_data >= rs2_data);
      default:     taken = 1'b0;
    endcase
  end

  always_comb begin
    if (halt) begin
      next_pc = pc;  // Park on the ECALL
    end else begin
      case (pc_sel)
        rv_pkg::NPC_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
        rv_pkg::NPC_JAL:    next_pc = pc_plus_imm;
        rv_pkg::NPC_JALR:   next_pc = {jalr_sum[31:1], 1'b0};
        default:            next_pc = pc_plus4;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_core (
  input  wire              clk,
  input  wire              rst,
  output rv_pkg::word_t    pc,
  input  rv_pkg::insn_t    insn,
  output logic             halt,
  output logic             illegal,
  output logic             wb_valid,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;
  rv_pkg::alu_op_t  alu_op;
  logic             alu_src_imm;
  logic             rf_we;
  rv_pkg::wb_sel_t  wb_sel;
  rv_pkg::pc_sel_t  pc_sel;
  logic [2:0]       branch_f3;
  logic             dec_halt;
  logic             dec_illegal;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    next_pc;
  logic             active;  // Low for the first edge after reset
  logic             rf_write;

  // First post-reset edge is a bubble, so the instruction at the reset PC
  // executes exactly once
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      pc     <= `RV_RESET_PC;
    end else begin
      active <= 1'b1;
      if (active) begin
        pc <= next_pc;
      end
    end
  end

  rv_decoder i_rv_decoder (
    .insn        (insn),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .rf_we       (rf_we),
    .wb_sel      (wb_sel),
    .pc_sel      (pc_sel),
    .branch_f3   (branch_f3),
    .halt        (dec_halt),
    .illegal     (dec_illegal)
  );

  assign rf_write = active && rf_we;

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_write),
    .rd       (rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  rv_alu i_rv_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_next_pc i_rv_next_pc (
    .pc        (pc),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc_sel    (pc_sel),
    .branch_f3 (branch_f3),
    .halt      (dec_halt),
    .next_pc   (next_pc)
  );

  // Write-back source
  always_comb begin
    case (wb_sel)
      rv_pkg::WB_IMM:    wb_data = imm;
      rv_pkg::WB_PC4:    wb_data = pc + 32'd4;
      rv_pkg::WB_PC_IMM: wb_data = pc + imm;
      default:           wb_data = alu_result;
    endcase
  end

  // Retirement trace
  assign wb_valid = rf_write && (rd != '0);
  assign wb_rd    = rd;

  assign halt    = active && dec_halt;
  assign illegal = active && dec_illegal;

endmodule

`default_nettype wire

// ==== sim/tb_rv_encode.svh ====
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

// Instruction encoders
function automatic rv_pkg::insn_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                         input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                         input rv_pkg::reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
endfunction

function automatic rv_pkg::insn_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                         input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                         input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::insn_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
                                         input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic rv_pkg::insn_t branch_insn(input logic [12:0] off, input logic [2:0] f3,
                                              input rv_pkg::reg_idx_t rs1,
                                              input rv_pkg::reg_idx_t rs2);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
endfunction

function automatic rv_pkg::insn_t jal_insn(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
endfunction

// Reference model of one RV32I instruction
function automatic void ref_step(
  input  rv_pkg::insn_t insn,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  output logic          we,
  output rv_pkg::word_t data,
  output rv_pkg::word_t npc,
  output logic          hlt,
  output logic          ill
);
  logic [2:0]    f3;
  logic [6:0]    f7;
  logic [4:0]    sh;
  logic          take;
  rv_pkg::word_t ii;
  rv_pkg::word_t ib;
  rv_pkg::word_t ij;
  f3 = insn[14:12];
  f7 = insn[31:25];
  sh = insn[24:20];
  ii = {{20{insn[31]}}, insn[31:20]};
  ib = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  ij = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  we = 1'b0;
  data = '0;
  npc = pc + 32'd4;
  hlt = 1'b0;
  ill = 1'b0;
  take = 1'b0;
  case (insn[6:0])
    `RV_OP_LUI: begin
      we = 1'b1;
      data = {insn[31:12], 12'h000};
    end
    `RV_OP_AUIPC: begin
      we = 1'b1;
      data = pc + {insn[31:12], 12'h000};
    end
    `RV_OP_JAL: begin
      we = 1'b1;
      data = pc + 32'd4;
      npc = pc + ij;
    end
    `RV_OP_JALR: begin
      we = 1'b1;
      data = pc + 32'd4;
      npc = (a + ii) & 32'hffff_fffe;  // Target LSB dropped
      ill = (f3 != `RV_F3_JALR);
    end
    `RV_OP_BRANCH: begin
      case (f3)
        `RV_F3_BEQ:  take = (a == b);
        `RV_F3_BNE:  take = (a != b);
        `RV_F3_BLT:  take = ($signed(a) < $signed(b));
        `RV_F3_BGE:  take = !($signed(a) < $signed(b));
        `RV_F3_BLTU: take = (a < b);
        `RV_F3_BGEU: take = !(a < b);
        default:     ill = 1'b1;
      endcase
      if (take) begin
        npc = pc + ib;
      end
    end
    `RV_OP_OP_IMM: begin
      we = 1'b1;
      case (f3)
        `RV_F3_ADD:  data = a + ii;
        `RV_F3_SLT:  data = {31'd0, $signed(a) < $signed(ii)};
        `RV_F3_SLTU: data = {31'd0, a < ii};
        `RV_F3_XOR:  data = a ^ ii;
        `RV_F3_OR:   data = a | ii;
        `RV_F3_AND:  data = a & ii;
        `RV_F3_SLL: begin
          data = a << sh;
          ill = (f7 != `RV_F7_BASE);
        end
        default: begin
          if (f7 == `RV_F7_ALT) begin
            data = $signed(a) >>> sh;
          end else begin
            data = a >> sh;
            ill = (f7 != `RV_F7_BASE);
          end
        end
      endcase
    end
    `RV_OP_OP: begin
      we = 1'b1;
      case ({f7, f3})
        {`RV_F7_BASE, `RV_F3_ADD}:  data = a + b;
        {`RV_F7_ALT,  `RV_F3_ADD}:  data = a - b;
        {`RV_F7_BASE, `RV_F3_SLL}:  data = a << b[4:0];
        {`RV_F7_BASE, `RV_F3_SLT}:  data = {31'd0, $signed(a) < $signed(b)};
        {`RV_F7_BASE, `RV_F3_SLTU}: data = {31'd0, a < b};
        {`RV_F7_BASE, `RV_F3_XOR}:  data = a ^ b;
        {`RV_F7_BASE, `RV_F3_SRL}:  data = a >> b[4:0];
        {`RV_F7_ALT,  `RV_F3_SRL}:  data = $signed(a) >>> b[4:0];
        {`RV_F7_BASE, `RV_F3_OR}:   data = a | b;
        {`RV_F7_BASE, `RV_F3_AND}:  data = a & b;
        default:                    ill = 1'b1;
      endcase
    end
    `RV_OP_MISC_MEM: ill = (f3 != `RV_F3_FENCE);
    `RV_OP_SYSTEM: begin
      if (insn[31:7] == 25'd0) begin
        hlt = 1'b1;
        npc = pc;  // ECALL parks the core
      end else begin
        ill = 1'b1;
      end
    end
    default: ill = 1'b1;
  endcase
  if (ill) begin
    we = 1'b0;
    npc = pc + 32'd4;
  end
endfunction

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;

  localparam int MEM_WORDS = 128;
  localparam int HALT_HOLD = 3;  // Halted cycles watched before the end

  logic             clk;
  logic             rst;
  rv_pkg::word_t    pc;
  rv_pkg::insn_t    insn;
  logic             halt;
  logic             illegal;
  logic             wb_valid;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;

  rv_pkg::insn_t imem [0:MEM_WORDS-1];
  rv_pkg::word_t m_regs [0:31];  // Model register file
  rv_pkg::word_t m_pc;
  logic [31:0]   lfsr;
  int            prog_len;
  int            cycle_limit;
  int            cycle_count;
  int            reset_edges;
  int            halt_cycles;
  logic          bubble;
  logic          done;

  `include "tb_rv_encode.svh"

  rv_core i_rv_core (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .halt     (halt),
    .illegal  (illegal),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  always #4 clk = ~clk;

  function automatic rv_pkg::insn_t fetch_word(input rv_pkg::word_t addr);
    return (addr[31:9] == '0) ? imem[addr[8:2]] : 32'h0000_0000;  // Out of range is illegal
  endfunction

  assign insn = fetch_word(pc);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string field, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, field, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input string field, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %b, expected %b", $time, field, got, exp);
      fail_run();
    end
  endtask

  task automatic check_idle();
    check_word("pc", pc, `RV_RESET_PC);
    check_flag("wb_valid", wb_valid, 1'b0);
    check_flag("halt", halt, 1'b0);
    check_flag("illegal", illegal, 1'b0);
  endtask

  task automatic emit(input rv_pkg::insn_t w);
    imem[7'(prog_len)] = w;
    prog_len++;
  endtask

  task automatic emit_filler();
    emit(i_type(12'h001, 5'd13, `RV_F3_ADD, 5'd13, `RV_OP_OP_IMM));  // addi x13, x13, 1
  endtask

  // Branch over one filler
  task automatic branch_slot(input logic [2:0] f3, input int rs1, input int rs2);
    emit(branch_insn(13'd8, f3, 5'(rs1), 5'(rs2)));
    emit_filler();
  endtask

  task automatic build_program();
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [11:0]      imm;
    logic             alt;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = 32'(i) << 7;  // Opcode 0 tagged with the word index
    end
    prog_len = 0;
    for (int r = 1; r <= 8; r++) begin
      emit(u_type(20'(draw_bits(20)), 5'(r), `RV_OP_LUI));
      emit(i_type(12'(draw_bits(12)), 5'(r), `RV_F3_ADD, 5'(r), `RV_OP_OP_IMM));
    end
    for (int n = 0; n < 40; n++) begin
      rd  = 5'(draw_bits(4));
      rs1 = 5'(draw_bits(4));
      rs2 = 5'(draw_bits(4));
      f3  = 3'(draw_bits(3));
      alt = 1'(draw_bits(1));
      if (draw_bits(1) != 0) begin
        // Alternate funct7 only on ADD and SRL
        f7 = (alt && (f3 == `RV_F3_ADD || f3 == `RV_F3_SRL)) ? `RV_F7_ALT : `RV_F7_BASE;
        emit(r_type(f7, rs2, rs1, f3, rd));
      end else begin
        imm = 12'(draw_bits(12));
        if (f3 == `RV_F3_SLL) begin
          imm = {`RV_F7_BASE, imm[4:0]};
        end else if (f3 == `RV_F3_SRL) begin
          imm = {alt ? `RV_F7_ALT : `RV_F7_BASE, imm[4:0]};
        end
        emit(i_type(imm, rs1, f3, rd, `RV_OP_OP_IMM));
      end
    end
    emit(i_type(12'h155, 5'd1, `RV_F3_ADD, 5'd0, `RV_OP_OP_IMM));  // Write to x0
    emit(r_type(`RV_F7_BASE, 5'd0, 5'd0, `RV_F3_ADD, 5'd9));     // Read x0 back
    emit(u_type(20'(draw_bits(20)), 5'd10, `RV_OP_AUIPC));
    emit(i_type(12'hfff, 5'd0, `RV_F3_ADD, 5'd11, `RV_OP_OP_IMM));  // x11 = -1
    emit(i_type(12'h001, 5'd0, `RV_F3_ADD, 5'd12, `RV_OP_OP_IMM));  // x12 = 1
    emit(r_type(`RV_F7_ALT, 5'd12, 5'd11, `RV_F3_ADD, 5'd17));
    emit(r_type(`RV_F7_ALT, 5'd12, 5'd11, `RV_F3_SRL, 5'd18));
    emit(r_type(`RV_F7_BASE, 5'd12, 5'd11, `RV_F3_SLT, 5'd19));
    emit(r_type(`RV_F7_BASE, 5'd12, 5'd11, `RV_F3_SLTU, 5'd20));
    emit(i_type({`RV_F7_ALT, 5'd4}, 5'd11, `RV_F3_SRL, 5'd21, `RV_OP_OP_IMM));
    // Taken first, then not taken
    branch_slot(`RV_F3_BEQ, 12, 12);
    branch_slot(`RV_F3_BEQ, 11, 12);
    branch_slot(`RV_F3_BNE, 11, 12);
    branch_slot(`RV_F3_BNE, 12, 12);
    branch_slot(`RV_F3_BLT, 11, 12);
    branch_slot(`RV_F3_BLT, 12, 11);
    branch_slot(`RV_F3_BGE, 12, 11);
    branch_slot(`RV_F3_BGE, 11, 12);
    branch_slot(`RV_F3_BLTU, 12, 11);
    branch_slot(`RV_F3_BLTU, 11, 12);
    branch_slot(`RV_F3_BGEU, 11, 12);
    branch_slot(`RV_F3_BGEU, 12, 11);
    emit(jal_insn(21'd12, 5'd14));
    emit_filler();
    emit_filler();
    emit(u_type(20'h00000, 5'd15, `RV_OP_AUIPC));
    emit(i_type(12'd13, 5'd15, `RV_F3_JALR, 5'd16, `RV_OP_JALR));  // Odd target
    emit_filler();
    emit(i_type(12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011));  // Load opcode is illegal
    emit(r_type(7'b0000001, 5'd2, 5'd1, `RV_F3_ADD, 5'd6));  // MUL is illegal
    emit(32'h0ff0_000f);  // FENCE
    emit(32'h0000_0073);  // ECALL
  endtask

  task automatic step_model();
    rv_pkg::insn_t    cur;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    data;
    rv_pkg::word_t    npc;
    logic             we;
    logic             hlt;
    logic             ill;
    logic             exp_valid;
    cur = fetch_word(m_pc);
    rd = cur[11:7];
    ref_step(cur, m_pc, m_regs[cur[19:15]], m_regs[cur[24:20]], we, data, npc, hlt, ill);
    exp_valid = we && (rd != 5'd0);
    check_word("pc", pc, m_pc);
    check_flag("wb_valid", wb_valid, exp_valid);
    if (exp_valid) begin
      check_word("wb_rd", 32'(wb_rd), 32'(rd));
      check_word("wb_data", wb_data, data);
      m_regs[rd] = data;
    end
    check_flag("halt", halt, hlt);
    check_flag("illegal", illegal, ill);
    m_pc = npc;
    if (hlt) begin
      halt_cycles++;
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (!done && cycle_count > cycle_limit) begin
      $display("Timeout: the core never halted within %0d cycles", cycle_limit);
      fail_run();
    end
    if (rst) begin
      if (reset_edges > 0) begin
        check_idle();  // pc is known once one reset edge has passed
      end
      reset_edges++;
      bubble = 1'b1;
    end else if (bubble) begin
      check_idle();  // First edge after reset
      bubble = 1'b0;
    end else if (!done) begin
      step_model();
      if (halt_cycles == HALT_HOLD) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    lfsr = 32'h74b2;
    done = 1'b0;
    bubble = 1'b1;
    reset_edges = 0;
    halt_cycles = 0;
    cycle_count = 0;
    m_pc = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    build_program();
    cycle_limit = 2 * prog_len + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (done);
    @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
+incdir+sim
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_next_pc.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

all: run

obj_dir/V$(TOP): tb.f include/rv_defs.svh verilog/*.sv sim/tb_rv_core.sv sim/tb_rv_encode.svh
	verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log; grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
